// ==== compile.f ====
hdl/trace_pkg.sv
hdl/trace_fifo.sv
hdl/trace_formatter.sv
hdl/trace_wb_slave.sv
hdl/trace_top.sv
tb/trace_tb_sva.sv
tb/trace_tb.sv

// ==== tb/trace_tb.sv ====
`timescale 1ns/10ps

module trace_tb;

    localparam int FIFO_DEPTH = 16;
    // six tests take well under 600 cycles, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 4000;
    // cycles between the two sampled retirements of test 3
    localparam int GAP = 10;

    logic               clk_i;
    logic               rst_n_i;
    trace_pkg::retire_t retire;
    trace_pkg::wb_req_t wb_req;
    trace_pkg::wb_rsp_t wb_rsp;

    int          errors;
    int          checks;
    int          cycles;
    logic [31:0] exp_q[$];
    logic        exp_is_hdr[$];
    logic [15:0] hdr_cycles[$];

    trace_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_trace_top (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .retire  (retire),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // cycle counter ends a hung run
    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        checks++;
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, act, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s finished, %0d errors so far", name, errors);
    endtask

    // one classic access with the request held until ack
    task automatic bus_access(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                              output logic [31:0] rdat);
        int waited;
        waited = 0;
        @(posedge clk_i);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        do begin
            @(posedge clk_i);
            #1;
            waited++;
        end while (!wb_rsp.ack && waited < 8);
        if (!wb_rsp.ack) begin
            $display("no ack from the slave for an access to address %0d", adr);
            errors++;
        end else begin
            // ack comes in the cycle after the request is sampled
            check("ack latency", waited, 1);
        end
        rdat       = wb_rsp.dat;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        bus_access(1'b1, adr, wdat, unused);
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [31:0] rdat);
        bus_access(1'b0, adr, 32'b0, rdat);
    endtask

    // valid is high for exactly one sampled edge
    task automatic retire_one(input trace_pkg::retire_t r);
        @(posedge clk_i);
        #1;
        retire       = r;
        retire.valid = 1'b1;
        @(posedge clk_i);
        #1;
        retire = '0;
    endtask

    function automatic trace_pkg::retire_t make_record(input logic gpr, input logic csr,
                                                       input logic trap);
        trace_pkg::retire_t r;
        r.valid     = 1'b1;
        r.pc        = $urandom;
        r.instr     = $urandom;
        r.trap      = trap;
        r.gpr_wb    = gpr;
        r.rd        = 5'($urandom);
        r.rd_wdata  = $urandom;
        r.csr_wb    = csr;
        r.csr_addr  = 12'($urandom);
        r.csr_wdata = $urandom;
        return r;
    endfunction

    function automatic int record_len(input trace_pkg::retire_t r);
        return 3 + (r.gpr_wb ? 1 : 0) + (r.csr_wb ? 2 : 0);
    endfunction

    // status layout is drops in 31..24, overflow in 16 and count in 15..0
    function automatic logic [31:0] status_word(input int drops, input logic ovf, input int cnt);
        return {8'(drops), 7'b0, ovf, 16'(cnt)};
    endfunction

    // expected words of one record with the header cycle left at zero
    task automatic push_expected(input trace_pkg::retire_t r);
        trace_pkg::trace_word_u eu;
        eu.raw        = '0;
        eu.hdr.rd     = r.rd;
        eu.hdr.len    = 3'(record_len(r));
        eu.hdr.trap   = r.trap;
        eu.hdr.gpr_wb = r.gpr_wb;
        eu.hdr.csr_wb = r.csr_wb;
        exp_q.push_back(eu.raw);
        exp_is_hdr.push_back(1'b1);
        exp_q.push_back(r.pc);
        exp_is_hdr.push_back(1'b0);
        exp_q.push_back(r.instr);
        exp_is_hdr.push_back(1'b0);
        if (r.gpr_wb) begin
            exp_q.push_back(r.rd_wdata);
            exp_is_hdr.push_back(1'b0);
        end
        if (r.csr_wb) begin
            exp_q.push_back({20'b0, r.csr_addr});
            exp_is_hdr.push_back(1'b0);
            exp_q.push_back(r.csr_wdata);
            exp_is_hdr.push_back(1'b0);
        end
    endtask

    // pops n words over the bus and compares them with the model
    task automatic pop_and_compare(input int n);
        trace_pkg::trace_word_u u;
        trace_pkg::trace_word_u eu;
        logic                   is_hdr;
        for (int i = 0; i < n; i++) begin
            wb_read(trace_pkg::REG_DATA, u.raw);
            if (exp_q.size() == 0) begin
                $display("word popped from the FIFO with no record expected");
                errors++;
            end else begin
                eu.raw = exp_q.pop_front();
                is_hdr = exp_is_hdr.pop_front();
                if (is_hdr) begin
                    check("hdr.len", u.hdr.len, eu.hdr.len);
                    check("hdr.rd", u.hdr.rd, eu.hdr.rd);
                    check("hdr.trap", u.hdr.trap, eu.hdr.trap);
                    check("hdr.gpr_wb", u.hdr.gpr_wb, eu.hdr.gpr_wb);
                    check("hdr.csr_wb", u.hdr.csr_wb, eu.hdr.csr_wb);
                    check("hdr.reserved", u.hdr.reserved, 5'b0);
                    hdr_cycles.push_back(u.hdr.cycle);
                end else begin
                    check("data word", u.raw, eu.raw);
                end
            end
        end
    endtask

    initial begin
        trace_pkg::retire_t r;
        trace_pkg::retire_t r2;
        logic [31:0]        rdat;
        errors  = 0;
        checks  = 0;
        cycles  = 0;
        rst_n_i = 1'b0;
        retire  = '0;
        wb_req  = '0;
        void'($urandom(32'he1f7_d298));
        repeat (5) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        // test 1 checks reset values and records ignored while disabled
        wb_read(trace_pkg::REG_STATUS, rdat);
        check("status", rdat, 32'b0);
        wb_read(trace_pkg::REG_CTRL, rdat);
        check("ctrl", rdat, 32'b0);
        retire_one(make_record(1'b1, 1'b1, 1'b0));
        repeat (8) @(posedge clk_i);
        wb_read(trace_pkg::REG_STATUS, rdat);
        check("status", rdat, 32'b0);
        report_test("1 reset and disabled");

        // test 2 covers every flag combination with trap on one of them
        wb_write(trace_pkg::REG_CTRL, 32'h1);
        for (int i = 0; i < 4; i++) begin
            r = make_record(i[0], i[1], i == 2);
            retire_one(r);
            push_expected(r);
            repeat (record_len(r) + 2) @(posedge clk_i);
            wb_read(trace_pkg::REG_STATUS, rdat);
            check("status.count", rdat[15:0], 16'(record_len(r)));
            pop_and_compare(record_len(r));
        end
        report_test("2 record formats");

        // test 3 samples two retirements GAP cycles apart
        hdr_cycles.delete();
        r = make_record(1'b0, 1'b0, 1'b0);
        retire_one(r);
        push_expected(r);
        repeat (GAP - 2) @(posedge clk_i);
        r = make_record(1'b0, 1'b0, 1'b0);
        retire_one(r);
        push_expected(r);
        repeat (5) @(posedge clk_i);
        pop_and_compare(6);
        if (hdr_cycles.size() == 2) begin
            check("hdr cycle gap", 16'(hdr_cycles[1] - hdr_cycles[0]), GAP);
        end else begin
            $display("expected two headers in the cycle test, got %0d", hdr_cycles.size());
            errors++;
        end
        report_test("3 cycle stamps");

        // test 4 retires a second record while the first is still being written
        r  = make_record(1'b1, 1'b1, 1'b0);
        r2 = make_record(1'b0, 1'b0, 1'b0);
        retire_one(r);
        retire_one(r2);
        push_expected(r);
        repeat (8) @(posedge clk_i);
        wb_read(trace_pkg::REG_STATUS, rdat);
        check("status", rdat, status_word(1, 1'b1, 6));
        pop_and_compare(6);
        wb_read(trace_pkg::REG_STATUS, rdat);
        check("status", rdat, status_word(1, 1'b1, 0));
        report_test("4 drop while busy");

        // test 5 leaves 4 free words after two full records
        for (int i = 0; i < 2; i++) begin
            r = make_record(1'b1, 1'b1, 1'b0);
            retire_one(r);
            push_expected(r);
            repeat (8) @(posedge clk_i);
        end
        wb_read(trace_pkg::REG_STATUS, rdat);
        check("status", rdat, status_word(1, 1'b1, 12));
        retire_one(make_record(1'b1, 1'b1, 1'b0));
        repeat (8) @(posedge clk_i);
        wb_read(trace_pkg::REG_STATUS, rdat);
        check("status", rdat, status_word(2, 1'b1, 12));
        r = make_record(1'b0, 1'b0, 1'b1);
        retire_one(r);
        push_expected(r);
        repeat (5) @(posedge clk_i);
        wb_read(trace_pkg::REG_STATUS, rdat);
        check("status", rdat, status_word(2, 1'b1, 15));
        report_test("5 fifo full");

        // test 6 flushes everything in the fifo with enable kept
        wb_write(trace_pkg::REG_CTRL, 32'h3);
        exp_q.delete();
        exp_is_hdr.delete();
        wb_read(trace_pkg::REG_STATUS, rdat);
        check("status", rdat, 32'b0);
        wb_read(trace_pkg::REG_CTRL, rdat);
        check("ctrl", rdat, 32'h1);
        wb_read(trace_pkg::REG_DATA, rdat);
        check("data", rdat, 32'b0);
        wb_read(trace_pkg::REG_STATUS, rdat);
        check("status", rdat, 32'b0);
        report_test("6 flush");

        // add the failures of the bound assertions
        if (i_trace_top.i_trace_wb_slave.i_trace_wb_sva.fail_cnt != 0) begin
            $display("assertion failures: %0d",
                     i_trace_top.i_trace_wb_slave.i_trace_wb_sva.fail_cnt);
            errors += i_trace_top.i_trace_wb_slave.i_trace_wb_sva.fail_cnt;
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== tb/trace_tb_sva.sv ====
`timescale 1ns/10ps

module trace_wb_sva #(
    parameter int FIFO_DEPTH = 32
) (
    input logic                        clk_i,
    input logic                        rst_n_i,
    input trace_pkg::wb_req_t          wb_req,
    input trace_pkg::wb_rsp_t          wb_rsp,
    input logic [$clog2(FIFO_DEPTH):0] count,
    input logic                        fifo_rd
);

    int fail_cnt = 0;

    // ack is a single cycle pulse
    ack_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            fail_cnt++;
            $error("ack high for two cycles");
        end

    // ack answers a request seen in the previous cycle
    ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else begin
            fail_cnt++;
            $error("ack without a preceding cyc and stb");
        end

    // pop only on an acked data read of a non-empty fifo
    pop_on_data_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fifo_rd |-> wb_rsp.ack &&
            $past(!wb_req.we && wb_req.adr == trace_pkg::REG_DATA && count != '0))
        else begin
            fail_cnt++;
            $error("fifo pop outside a data read");
        end

endmodule

bind trace_wb_slave trace_wb_sva #(
    .FIFO_DEPTH (FIFO_DEPTH)
) i_trace_wb_sva (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .count   (count),
    .fifo_rd (fifo_rd)
);

// ==== hdl/trace_top.sv ====
`timescale 1ns/10ps

module trace_top #(
    parameter int FIFO_DEPTH = 32
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  trace_pkg::retire_t retire,
    input  trace_pkg::wb_req_t wb_req,
    output trace_pkg::wb_rsp_t wb_rsp
);

    // formatter to fifo
    logic        fifo_wr;
    logic [31:0] fifo_wdata;
    // fifo state seen by formatter and slave
    logic [$clog2(FIFO_DEPTH):0] count;
    logic [31:0] rdata;
    // slave controls
    logic        fifo_rd;
    logic        flush;
    logic        enable;
    // refused record pulse
    logic        drop;

    trace_formatter #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_trace_formatter (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .retire     (retire),
        .enable     (enable),
        .count      (count),
        .fifo_wr    (fifo_wr),
        .fifo_wdata (fifo_wdata),
        .drop       (drop)
    );

    trace_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_trace_fifo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .wr      (fifo_wr),
        .wdata   (fifo_wdata),
        .rd      (fifo_rd),
        .flush   (flush),
        .rdata   (rdata),
        .count   (count)
    );

    trace_wb_slave #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_trace_wb_slave (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .wb_req  (wb_req),
        .count   (count),
        .rdata   (rdata),
        .drop    (drop),
        .wb_rsp  (wb_rsp),
        .fifo_rd (fifo_rd),
        .enable  (enable),
        .flush   (flush)
    );

endmodule

// ==== hdl/trace_wb_slave.sv ====
`timescale 1ns/10ps

module trace_wb_slave #(
    parameter int FIFO_DEPTH = 32
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  trace_pkg::wb_req_t          wb_req,
    input  logic [$clog2(FIFO_DEPTH):0] count,
    input  logic [31:0]                 rdata,
    input  logic                        drop,
    output trace_pkg::wb_rsp_t          wb_rsp,
    output logic                        fifo_rd,
    output logic                        enable,
    output logic                        flush
);

    logic        ack_q;
    logic [31:0] dat_q;
    logic        acc;
    logic        overflow;
    logic [7:0]  drop_cnt;
    logic [31:0] rd_mux;

    // new access sampled while ack is low
    assign acc = wb_req.cyc && wb_req.stb && !ack_q;

    // read data mux, sampled in the access cycle
    always_comb begin
        case (wb_req.adr)
            trace_pkg::REG_STATUS: rd_mux = {drop_cnt, 7'b0, overflow, 16'(count)};
            // empty fifo reads as zero
            trace_pkg::REG_DATA:   rd_mux = (count != '0) ? rdata : 32'b0;
            trace_pkg::REG_CTRL:   rd_mux = {31'b0, enable};
            default:               rd_mux = 32'b0;
        endcase
    end

    always_ff @(posedge clk_i, negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q   <= 1'b0;
            fifo_rd <= 1'b0;
            flush   <= 1'b0;
            enable  <= 1'b0;
        end else begin
            // single cycle ack, one cycle after the access
            ack_q   <= acc;
            // pop lands in the ack cycle, head was already captured
            fifo_rd <= acc && !wb_req.we && (wb_req.adr == trace_pkg::REG_DATA) &&
                       (count != '0);
            flush   <= acc && wb_req.we && (wb_req.adr == trace_pkg::REG_CTRL) &&
                       wb_req.dat[1];
            if (acc && wb_req.we && (wb_req.adr == trace_pkg::REG_CTRL)) begin
                enable <= wb_req.dat[0];
            end
        end
    end

    // sticky overflow and saturating drop counter
    always_ff @(posedge clk_i, negedge rst_n_i) begin
        if (!rst_n_i) begin
            overflow <= 1'b0;
            drop_cnt <= '0;
        end else if (flush) begin
            overflow <= 1'b0;
            drop_cnt <= '0;
        end else if (drop) begin
            overflow <= 1'b1;
            if (drop_cnt != 8'hff) begin
                drop_cnt <= drop_cnt + 8'd1;
            end
        end
    end

    // read data held for the ack cycle
    always_ff @(posedge clk_i) begin
        if (acc && !wb_req.we) begin
            dat_q <= rd_mux;
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = dat_q;

endmodule

// ==== hdl/trace_formatter.sv ====
`timescale 1ns/10ps

module trace_formatter #(
    parameter int FIFO_DEPTH = 32
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  trace_pkg::retire_t        retire,
    input  logic                      enable,
    input  logic [$clog2(FIFO_DEPTH):0] count,
    output logic                      fifo_wr,
    output logic [31:0]               fifo_wdata,
    output logic                      drop
);

    localparam int CW = $clog2(FIFO_DEPTH) + 1;
    localparam int IW = $clog2(trace_pkg::MAX_RECORD_LEN);

    logic [15:0]            cycle_cnt;
    logic                   busy;
    logic [IW-1:0]          idx;
    logic [IW-1:0]          idx_nxt;
    logic                   last;
    logic [2:0]             len;
    logic [CW-1:0]          free;
    logic                   accept;
    trace_pkg::trace_word_u hdr_w;
    trace_pkg::retire_t     hold;
    logic [31:0]            hdr_q;

    // free-running, zero in the first cycle out of reset
    always_ff @(posedge clk_i, negedge rst_n_i) begin
        if (!rst_n_i) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 16'd1;
        end
    end

    // record length, 3 base words plus the optional ones
    assign len = 3'd3 + {2'b0, retire.gpr_wb} + {1'b0, retire.csr_wb, 1'b0};

    // count may lag pops by a cycle, so this is conservative
    assign free = CW'(FIFO_DEPTH) - count;

    // whole record must fit, partial records never reach the fifo
    assign accept = retire.valid && enable && !busy && (free >= CW'(len));

    // header built from the live record in the accept cycle
    always_comb begin
        hdr_w.raw          = '0;
        hdr_w.hdr.cycle    = cycle_cnt;
        hdr_w.hdr.rd       = retire.rd;
        hdr_w.hdr.len      = len;
        hdr_w.hdr.trap     = retire.trap;
        hdr_w.hdr.gpr_wb   = retire.gpr_wb;
        hdr_w.hdr.csr_wb   = retire.csr_wb;
        hdr_w.hdr.reserved = '0;
    end

    // word order: hdr, pc, instr, rd data, csr addr, csr data
    // absent optional words are skipped
    always_comb begin
        idx_nxt = idx + 1'b1;
        last    = 1'b0;
        case (idx)
            IW'(2): begin
                if (hold.gpr_wb) begin
                    idx_nxt = IW'(3);
                end else if (hold.csr_wb) begin
                    idx_nxt = IW'(4);
                end else begin
                    last = 1'b1;
                end
            end
            IW'(3): begin
                // csr pair follows only if present
                last = !hold.csr_wb;
            end
            IW'(5): begin
                last = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk_i, negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy <= 1'b0;
            idx  <= '0;
            drop <= 1'b0;
        end else begin
            if (accept) begin
                busy <= 1'b1;
                idx  <= '0;
            end else if (busy) begin
                // idle again once the last word is out
                busy <= !last;
                idx  <= idx_nxt;
            end
            // refused while enabled, one cycle pulse to the slave
            drop <= retire.valid && enable && !accept;
        end
    end

    // holding register for the accepted record
    always_ff @(posedge clk_i) begin
        if (accept) begin
            hold  <= retire;
            hdr_q <= hdr_w.raw;
        end
    end

    // one word per busy cycle
    assign fifo_wr = busy;

    always_comb begin
        case (idx)
            IW'(0):  fifo_wdata = hdr_q;
            IW'(1):  fifo_wdata = hold.pc;
            IW'(2):  fifo_wdata = hold.instr;
            IW'(3):  fifo_wdata = hold.rd_wdata;
            IW'(4):  fifo_wdata = {20'b0, hold.csr_addr};
            default: fifo_wdata = hold.csr_wdata;
        endcase
    end

endmodule

// ==== hdl/trace_fifo.sv ====
`timescale 1ns/10ps

module trace_fifo #(
    parameter int FIFO_DEPTH = 32
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        wr,
    input  logic [31:0]                 wdata,
    input  logic                        rd,
    input  logic                        flush,
    output logic [31:0]                 rdata,
    output logic [$clog2(FIFO_DEPTH):0] count
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [31:0]   mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          empty;
    logic          full;
    logic          do_wr;
    logic          do_rd;

    assign empty = (count == '0);
    assign full  = (count == (AW+1)'(FIFO_DEPTH));

    // pop only real data
    assign do_rd = rd && !empty;
    // a pop in the same cycle frees the slot for a write
    assign do_wr = wr && (!full || do_rd);

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk_i, negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            // flush drops everything in one cycle
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // first word fall through, head is always on rdata
    assign rdata = mem[rd_ptr];

endmodule

// ==== hdl/trace_pkg.sv ====
package trace_pkg;

    // one retirement per cycle
    // only slot [0][0] of the core's retirement record is kept
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
        logic        trap;
        // single gpr write of the instruction
        logic        gpr_wb;
        logic [4:0]  rd;
        logic [31:0] rd_wdata;
        // single csr write of the instruction
        logic        csr_wb;
        logic [11:0] csr_addr;
        logic [31:0] csr_wdata;
    } retire_t;

    // first word of every record
    typedef struct packed {
        // low half of the cycle counter at capture
        logic [15:0] cycle;
        logic [4:0]  rd;
        // total words in the record, 3 to 6
        logic [2:0]  len;
        logic        trap;
        logic        gpr_wb;
        logic        csr_wb;
        // always zero
        logic [4:0]  reserved;
    } trace_hdr_t;

    // a fifo word is either a header or raw payload
    typedef union packed {
        logic [31:0] raw;
        trace_hdr_t  hdr;
    } trace_word_u;

    // wishbone classic, master side
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        // word address
        logic [3:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    // wishbone classic, slave side
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // register map, word addresses
    localparam logic [3:0] REG_STATUS = 4'd0;
    localparam logic [3:0] REG_DATA   = 4'd1;
    localparam logic [3:0] REG_CTRL   = 4'd2;

    // header, pc, instr, rd data, csr address, csr data
    localparam int MAX_RECORD_LEN = 6;

endpackage
